//--- design/llc_settings.svh
`ifndef LLC_SETTINGS_SVH
`define LLC_SETTINGS_SVH

// byte address width seen by the cache.
`define LLC_ADDR_BITS 32

// byte offset within one cache line.
`define LLC_OFFSET_BITS 4

// line address, the byte address without its offset.
`define LLC_LINE_ADDR_BITS (`LLC_ADDR_BITS - `LLC_OFFSET_BITS)

// set index width.
// a small index keeps the reset and flush walk short.
`define LLC_SET_BITS 4

// tag is what remains of the line address above the set index.
`define LLC_TAG_BITS (`LLC_LINE_ADDR_BITS - `LLC_SET_BITS)

`endif

//--- design/llc_pkg.sv
`include "llc_settings.svh"

package llc_pkg;

    // line address, byte address with the offset removed.
    typedef logic [`LLC_LINE_ADDR_BITS-1:0] line_addr_t;

    // set index into the tag and data arrays.
    typedef logic [`LLC_SET_BITS-1:0] llc_set_t;

    // tag stored alongside each way.
    typedef logic [`LLC_TAG_BITS-1:0] llc_tag_t;

    // source granted by the input selector in the current cycle.
    // values are fixed so that they can be observed directly on sel.
    typedef enum logic [2:0] {
        SRC_NONE       = 3'd0,
        SRC_WALK       = 3'd1,
        SRC_RSP        = 3'd2,
        SRC_REQ        = 3'd3,
        SRC_DMA_REQ    = 3'd4,
        SRC_DMA_RESUME = 3'd5
    } src_sel_t;

endpackage

//--- design/llc_input_select.sv
module llc_input_select (
    input  logic             rsp_valid,
    input  logic             req_valid,
    input  logic             dma_req_valid,
    input  logic             dma_read_resume,
    input  logic             dma_write_resume,
    input  logic             rst_stall,
    input  logic             flush_stall,
    input  logic             req_stall,
    output logic             is_rst_to_resume,
    output logic             is_flush_to_resume,
    output logic             is_rsp_to_get,
    output logic             is_req_to_get,
    output logic             is_dma_req_to_get,
    output logic             is_dma_read_to_resume,
    output logic             is_dma_write_to_resume,
    output logic             rd_set_en,
    output llc_pkg::src_sel_t sel
);

    import llc_pkg::*;

    // fixed priority, one winner at most per cycle.
    always_comb begin
        is_rst_to_resume       = 1'b0;
        is_flush_to_resume     = 1'b0;
        is_rsp_to_get          = 1'b0;
        is_req_to_get          = 1'b0;
        is_dma_req_to_get      = 1'b0;
        is_dma_read_to_resume  = 1'b0;
        is_dma_write_to_resume = 1'b0;
        sel                    = SRC_NONE;

        if (rst_stall) begin
            // a flush raised during the reset walk rides along with it.
            is_rst_to_resume = 1'b1;
            sel              = SRC_WALK;
        end else if (flush_stall) begin
            is_flush_to_resume = 1'b1;
            sel                = SRC_WALK;
        end else if (rsp_valid) begin
            is_rsp_to_get = 1'b1;
            sel           = SRC_RSP;
        end else if (req_valid && !req_stall) begin
            is_req_to_get = 1'b1;
            sel           = SRC_REQ;
        end else if (dma_req_valid) begin
            is_dma_req_to_get = 1'b1;
            sel               = SRC_DMA_REQ;
        end else if (dma_read_resume) begin
            is_dma_read_to_resume = 1'b1;
            sel                   = SRC_DMA_RESUME;
        end else if (dma_write_resume) begin
            is_dma_write_to_resume = 1'b1;
            sel                    = SRC_DMA_RESUME;
        end
    end

    // any grant reads a set this cycle.
    assign rd_set_en = (sel != SRC_NONE);

endmodule

//--- design/llc_read_set.sv
`include "llc_settings.svh"

module llc_read_set (
    input  logic                clk,
    input  logic                rst,
    input  logic                rd_set_en,
    input  logic                is_rst_to_resume,
    input  logic                is_flush_to_resume,
    input  logic                is_rsp_to_get,
    input  logic                is_req_to_get,
    input  logic                is_dma_req_to_get,
    input  logic                is_dma_read_to_resume,
    input  logic                is_dma_write_to_resume,
    input  logic                req_stall,
    input  llc_pkg::line_addr_t rsp_in_addr,
    input  llc_pkg::line_addr_t req_in_addr,
    input  llc_pkg::line_addr_t dma_req_in_addr,
    input  llc_pkg::line_addr_t dma_addr,
    input  llc_pkg::llc_set_t   rst_flush_stalled_set,
    input  llc_pkg::llc_set_t   req_in_stalled_set,
    input  llc_pkg::llc_tag_t   req_in_stalled_tag,
    output llc_pkg::llc_set_t   set,
    output llc_pkg::llc_set_t   set_next,
    output llc_pkg::llc_tag_t   tag,
    output logic                incr_rst_flush_stalled_set,
    output logic                clr_rst_stall,
    output logic                clr_flush_stall,
    output logic                clr_req_stall,
    output logic                update_dma_addr_from_req
);

    import llc_pkg::*;

    line_addr_t addr_for_set;
    llc_tag_t   tag_from_addr;
    llc_set_t   set_from_addr;
    llc_tag_t   tag_q;
    llc_set_t   set_q;
    logic       walk;

    assign walk = is_rst_to_resume | is_flush_to_resume;

    // address of the granted source; zero when nothing with an address wins.
    always_comb begin
        addr_for_set = '0;
        if (is_rsp_to_get) begin
            addr_for_set = rsp_in_addr;
        end else if (is_req_to_get) begin
            addr_for_set = req_in_addr;
        end else if (is_dma_req_to_get) begin
            addr_for_set = dma_req_in_addr;
        end else if (is_dma_read_to_resume || is_dma_write_to_resume) begin
            addr_for_set = dma_addr;
        end
    end

    assign tag_from_addr = addr_for_set[`LLC_LINE_ADDR_BITS-1:`LLC_SET_BITS];
    assign set_from_addr = addr_for_set[`LLC_SET_BITS-1:0];

    // a new DMA request becomes the line that later resumes continue from.
    assign update_dma_addr_from_req = is_dma_req_to_get;

    always_comb begin
        incr_rst_flush_stalled_set = 1'b0;
        clr_rst_stall              = 1'b0;
        clr_flush_stall            = 1'b0;
        clr_req_stall              = 1'b0;

        if (walk) begin
            incr_rst_flush_stalled_set = 1'b1;
            // the last set ends both walks at once.
            if (rst_flush_stalled_set == {`LLC_SET_BITS{1'b1}}) begin
                clr_rst_stall   = 1'b1;
                clr_flush_stall = 1'b1;
            end
        end else if (is_rsp_to_get) begin
            // a response to the stalled line lets the request retry.
            if (req_stall && (tag_from_addr == req_in_stalled_tag)
                    && (set_from_addr == req_in_stalled_set)) begin
                clr_req_stall = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            tag_q <= '0;
            set_q <= '0;
        end else if (rd_set_en) begin
            tag_q <= tag_from_addr;
            set_q <= set_from_addr;
        end
    end

    assign set_next = walk ? rst_flush_stalled_set : set_from_addr;
    assign set      = walk ? rst_flush_stalled_set : set_q;
    assign tag      = tag_q;

endmodule

//--- design/llc_stall_tracker.sv
module llc_stall_tracker (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush_start,
    input  logic                req_stall_set,
    input  logic                incr_rst_flush_stalled_set,
    input  logic                clr_rst_stall,
    input  logic                clr_flush_stall,
    input  logic                clr_req_stall,
    input  logic                update_dma_addr_from_req,
    input  llc_pkg::line_addr_t dma_req_in_addr,
    input  llc_pkg::llc_set_t   set,
    input  llc_pkg::llc_tag_t   tag,
    output logic                rst_stall,
    output logic                flush_stall,
    output logic                req_stall,
    output llc_pkg::llc_set_t   rst_flush_stalled_set,
    output llc_pkg::llc_set_t   req_in_stalled_set,
    output llc_pkg::llc_tag_t   req_in_stalled_tag,
    output llc_pkg::line_addr_t dma_addr
);

    import llc_pkg::*;

    // walk counter, shared by the reset and the flush walk.
    // it wraps back to zero after the last set.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rst_flush_stalled_set <= '0;
        end else if (incr_rst_flush_stalled_set) begin
            rst_flush_stalled_set <= rst_flush_stalled_set + 1'b1;
        end
    end

    // the cache comes out of reset needing every set cleared.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rst_stall <= 1'b1;
        end else if (clr_rst_stall) begin
            rst_stall <= 1'b0;
        end
    end

    // a new flush wins over the end of a walk in the same cycle.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            flush_stall <= 1'b0;
        end else if (flush_start) begin
            flush_stall <= 1'b1;
        end else if (clr_flush_stall) begin
            flush_stall <= 1'b0;
        end
    end

    // only one request can be parked at a time.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_stall <= 1'b0;
        end else if (req_stall_set) begin
            req_stall <= 1'b1;
        end else if (clr_req_stall) begin
            req_stall <= 1'b0;
        end
    end

    // tag and set were registered on the grant one cycle before the stall pulse.
    always_ff @(posedge clk) begin
        if (req_stall_set) begin
            req_in_stalled_tag <= tag;
            req_in_stalled_set <= set;
        end
    end

    // line that a DMA read or write resumes from.
    always_ff @(posedge clk) begin
        if (update_dma_addr_from_req) begin
            dma_addr <= dma_req_in_addr;
        end
    end

endmodule

//--- design/llc_front_top.sv
module llc_front_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                rsp_valid,
    input  llc_pkg::line_addr_t rsp_in_addr,
    input  logic                req_valid,
    input  llc_pkg::line_addr_t req_in_addr,
    input  logic                dma_req_valid,
    input  llc_pkg::line_addr_t dma_req_in_addr,
    input  logic                dma_read_resume,
    input  logic                dma_write_resume,
    input  logic                flush_start,
    input  logic                req_stall_set,
    output llc_pkg::src_sel_t   sel,
    output llc_pkg::llc_set_t   set,
    output llc_pkg::llc_set_t   set_next,
    output llc_pkg::llc_tag_t   tag,
    output logic                rst_stall,
    output logic                flush_stall,
    output logic                req_stall,
    output llc_pkg::line_addr_t dma_addr
);

    import llc_pkg::*;

    logic     is_rst_to_resume;
    logic     is_flush_to_resume;
    logic     is_rsp_to_get;
    logic     is_req_to_get;
    logic     is_dma_req_to_get;
    logic     is_dma_read_to_resume;
    logic     is_dma_write_to_resume;
    logic     rd_set_en;
    logic     incr_rst_flush_stalled_set;
    logic     clr_rst_stall;
    logic     clr_flush_stall;
    logic     clr_req_stall;
    logic     update_dma_addr_from_req;
    llc_set_t rst_flush_stalled_set;
    llc_set_t req_in_stalled_set;
    llc_tag_t req_in_stalled_tag;

    llc_input_select u_input_select (
        .rsp_valid              (rsp_valid),
        .req_valid              (req_valid),
        .dma_req_valid          (dma_req_valid),
        .dma_read_resume        (dma_read_resume),
        .dma_write_resume       (dma_write_resume),
        .rst_stall              (rst_stall),
        .flush_stall            (flush_stall),
        .req_stall              (req_stall),
        .is_rst_to_resume       (is_rst_to_resume),
        .is_flush_to_resume     (is_flush_to_resume),
        .is_rsp_to_get          (is_rsp_to_get),
        .is_req_to_get          (is_req_to_get),
        .is_dma_req_to_get      (is_dma_req_to_get),
        .is_dma_read_to_resume  (is_dma_read_to_resume),
        .is_dma_write_to_resume (is_dma_write_to_resume),
        .rd_set_en              (rd_set_en),
        .sel                    (sel)
    );

    llc_read_set u_read_set (
        .clk                        (clk),
        .rst                        (rst),
        .rd_set_en                  (rd_set_en),
        .is_rst_to_resume           (is_rst_to_resume),
        .is_flush_to_resume         (is_flush_to_resume),
        .is_rsp_to_get              (is_rsp_to_get),
        .is_req_to_get              (is_req_to_get),
        .is_dma_req_to_get          (is_dma_req_to_get),
        .is_dma_read_to_resume      (is_dma_read_to_resume),
        .is_dma_write_to_resume     (is_dma_write_to_resume),
        .req_stall                  (req_stall),
        .rsp_in_addr                (rsp_in_addr),
        .req_in_addr                (req_in_addr),
        .dma_req_in_addr            (dma_req_in_addr),
        .dma_addr                   (dma_addr),
        .rst_flush_stalled_set      (rst_flush_stalled_set),
        .req_in_stalled_set         (req_in_stalled_set),
        .req_in_stalled_tag         (req_in_stalled_tag),
        .set                        (set),
        .set_next                   (set_next),
        .tag                        (tag),
        .incr_rst_flush_stalled_set (incr_rst_flush_stalled_set),
        .clr_rst_stall              (clr_rst_stall),
        .clr_flush_stall            (clr_flush_stall),
        .clr_req_stall              (clr_req_stall),
        .update_dma_addr_from_req   (update_dma_addr_from_req)
    );

    llc_stall_tracker u_stall_tracker (
        .clk                        (clk),
        .rst                        (rst),
        .flush_start                (flush_start),
        .req_stall_set              (req_stall_set),
        .incr_rst_flush_stalled_set (incr_rst_flush_stalled_set),
        .clr_rst_stall              (clr_rst_stall),
        .clr_flush_stall            (clr_flush_stall),
        .clr_req_stall              (clr_req_stall),
        .update_dma_addr_from_req   (update_dma_addr_from_req),
        .dma_req_in_addr            (dma_req_in_addr),
        .set                        (set),
        .tag                        (tag),
        .rst_stall                  (rst_stall),
        .flush_stall                (flush_stall),
        .req_stall                  (req_stall),
        .rst_flush_stalled_set      (rst_flush_stalled_set),
        .req_in_stalled_set         (req_in_stalled_set),
        .req_in_stalled_tag         (req_in_stalled_tag),
        .dma_addr                   (dma_addr)
    );

endmodule

//--- dv/llc_tb_clock.sv
module llc_tb_clock (
    output logic clk,
    output logic rst
);

    // period of 20 time units.
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset stays low over the first two rising edges.
    initial begin
        rst = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

//--- dv/llc_front_tb.sv
module llc_front_tb;

    import llc_pkg::*;

    localparam int MAX_VECS = 64;
    localparam int ROW_BITS = 132;

    logic                clk;
    logic                rst;
    logic                rsp_valid;
    line_addr_t          rsp_in_addr;
    logic                req_valid;
    line_addr_t          req_in_addr;
    logic                dma_req_valid;
    line_addr_t          dma_req_in_addr;
    logic                dma_read_resume;
    logic                dma_write_resume;
    logic                flush_start;
    logic                req_stall_set;
    src_sel_t            sel;
    llc_set_t            set;
    llc_set_t            set_next;
    llc_tag_t            tag;
    logic                rst_stall;
    logic                flush_stall;
    logic                req_stall;
    line_addr_t          dma_addr;
    logic [ROW_BITS-1:0] vectors [0:MAX_VECS-1];
    int                  vec_count;
    int                  row_index;
    int                  cycle_count = 0;
    int                  timeout_limit = MAX_VECS + 20;
    line_addr_t          dma_addr_exp;
    logic                dma_addr_known;

    llc_tb_clock clock0 (
        .clk (clk),
        .rst (rst)
    );

    llc_front_top dut0 (
        .clk              (clk),
        .rst              (rst),
        .rsp_valid        (rsp_valid),
        .rsp_in_addr      (rsp_in_addr),
        .req_valid        (req_valid),
        .req_in_addr      (req_in_addr),
        .dma_req_valid    (dma_req_valid),
        .dma_req_in_addr  (dma_req_in_addr),
        .dma_read_resume  (dma_read_resume),
        .dma_write_resume (dma_write_resume),
        .flush_start      (flush_start),
        .req_stall_set    (req_stall_set),
        .sel              (sel),
        .set              (set),
        .set_next         (set_next),
        .tag              (tag),
        .rst_stall        (rst_stall),
        .flush_stall      (flush_stall),
        .req_stall        (req_stall),
        .dma_addr         (dma_addr)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s in row %0d: got 0x%h, expected 0x%h",
                     name, row_index, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "output check failed");
        end
    endtask

    task automatic drive_row(input logic [ROW_BITS-1:0] row);
        rsp_valid        <= row[130];
        req_valid        <= row[129];
        dma_req_valid    <= row[128];
        dma_read_resume  <= row[127];
        dma_write_resume <= row[126];
        flush_start      <= row[125];
        req_stall_set    <= row[124];
        rsp_in_addr      <= row[123:96];
        req_in_addr      <= row[95:68];
        dma_req_in_addr  <= row[67:40];
    endtask

    task automatic check_row(input logic [ROW_BITS-1:0] row);
        check_value("sel", 32'(sel), 32'(row[39:36]));
        check_value("set_next", 32'(set_next), 32'(row[35:32]));
        check_value("set", 32'(set), 32'(row[31:28]));
        check_value("rst_stall", 32'(rst_stall), 32'(row[26]));
        check_value("flush_stall", 32'(flush_stall), 32'(row[25]));
        check_value("req_stall", 32'(req_stall), 32'(row[24]));
        check_value("tag", 32'(tag), 32'(row[23:0]));
        // dma_addr holds the address of the last granted DMA request.
        if (dma_addr_known) begin
            check_value("dma_addr", 32'(dma_addr), 32'(dma_addr_exp));
        end
    endtask

    always @(posedge clk) begin
        if (cycle_count >= timeout_limit) begin
            $display("timeout: the vectors did not finish within %0d cycles", cycle_count);
            $display("RESULT: FAIL");
            $fatal(1, "run stopped by the cycle limit");
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    initial begin
        rsp_valid        = 1'b0;
        req_valid        = 1'b0;
        dma_req_valid    = 1'b0;
        dma_read_resume  = 1'b0;
        dma_write_resume = 1'b0;
        flush_start      = 1'b0;
        req_stall_set    = 1'b0;
        rsp_in_addr      = '0;
        req_in_addr      = '0;
        dma_req_in_addr  = '0;
        row_index        = 0;
        dma_addr_exp     = '0;
        dma_addr_known   = 1'b0;

        $readmemh("dv/llc_front_testdata.hex", vectors);

        // a row whose flag byte is FF ends the table.
        vec_count = 0;
        while (vec_count < MAX_VECS && vectors[vec_count][131:124] !== 8'hFF) begin
            vec_count++;
        end
        if (vec_count == 0 || vec_count == MAX_VECS) begin
            $display("the data file holds no vectors or lacks its end marker");
            $display("RESULT: FAIL");
            $fatal(1, "unusable test data");
        end
        timeout_limit = vec_count + 20;

        // row 0 goes out on the edge that releases reset.
        @(posedge rst);
        for (row_index = 0; row_index < vec_count; row_index++) begin
            if (row_index > 0) begin
                @(posedge clk);
            end
            drive_row(vectors[row_index]);
            @(negedge clk);
            check_row(vectors[row_index]);
            // the DMA line register loads at the edge that ends a DMA request grant.
            if (vectors[row_index][39:36] == 4'(SRC_DMA_REQ)) begin
                dma_addr_exp   = vectors[row_index][67:40];
                dma_addr_known = 1'b1;
            end
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- llc_front.f
+incdir+design
design/llc_pkg.sv
design/llc_input_select.sv
design/llc_read_set.sv
design/llc_stall_tracker.sv
design/llc_front_top.sv
dv/llc_tb_clock.sv
dv/llc_front_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing -Wno-fatal --top-module llc_front_tb \
    -f llc_front.f -Mdir build/obj_dir -o llc_front_sim

# the simulator exits non-zero on a failed check, the log decides the verdict.
./build/obj_dir/llc_front_sim > build/sim.log 2>&1 || true
cat build/sim.log

if grep -q "RESULT: FAIL" build/sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "RESULT: PASS" build/sim.log; then
    echo "simulation ended without a verdict"
    exit 1
fi
echo "simulation passed"

//--- dv/llc_front_testdata.hex
// hex digits from the left: 2 input flags (bits 6..0 are rsp, req, dma_req, dma_read,
// dma_write, flush_start, req_stall_set), 7 rsp_in_addr, 7 req_in_addr, 7 dma_req_in_addr,
// then expected 1 sel, 1 set_next, 1 set, 1 stall flags (bits 2..0 rst, flush, req), 6 tag.
// a row starting with FF ends the table.
7CAB123450C0FFE75A5A5A91004000000
7CAB123450C0FFE75A5A5A91114000000
7CAB123450C0FFE75A5A5A91224000000
7CAB123450C0FFE75A5A5A91334000000
7CAB123450C0FFE75A5A5A91444000000
7CAB123450C0FFE75A5A5A91554000000
7CAB123450C0FFE75A5A5A91664000000
7CAB123450C0FFE75A5A5A91774000000
7CAB123450C0FFE75A5A5A91884000000
7CAB123450C0FFE75A5A5A91994000000
7CAB123450C0FFE75A5A5A91AA4000000
7CAB123450C0FFE75A5A5A91BB4000000
7CAB123450C0FFE75A5A5A91CC4000000
7CAB123450C0FFE75A5A5A91DD4000000
7CAB123450C0FFE75A5A5A91EE4000000
7CAB123450C0FFE75A5A5A91FF4000000
70AB123450C0FFE75A5A5A92500000000
30AB123450C0FFE75A5A5A93750AB1234
10AB123450C0FFE75A5A5A949700C0FFE
08AB123450C0FFE75A5A5A959905A5A5A
04AB123450C0FFE75A5A5A959905A5A5A
00AB123450C0FFE75A5A5A900905A5A5A
20AB123450C0FFE75A5A5A937905A5A5A
01AB123450C0FFE75A5A5A900700C0FFE
20AB123450C0FFE75A5A5A900710C0FFE
30AB123450C0FFE73C3C3C242710C0FFE
60AB123450C0FFE73C3C3C225213C3C3C
60AB123470C0FFE73C3C3C22751AB1234
600C0FFE70C0FFE73C3C3C22771AB1234
20AB123450C0FFE73C3C3C237700C0FFE
08AB123450C0FFE73C3C3C252700C0FFE
00AB123450C0FFE73C3C3C200203C3C3C
02AB123450C0FFE73C3C3C200203C3C3C
40AB123450C0FFE73C3C3C210023C3C3C
40AB123450C0FFE73C3C3C21112000000
40AB123450C0FFE73C3C3C21222000000
40AB123450C0FFE73C3C3C21332000000
40AB123450C0FFE73C3C3C21442000000
40AB123450C0FFE73C3C3C21552000000
40AB123450C0FFE73C3C3C21662000000
40AB123450C0FFE73C3C3C21772000000
40AB123450C0FFE73C3C3C21882000000
40AB123450C0FFE73C3C3C21992000000
40AB123450C0FFE73C3C3C21AA2000000
40AB123450C0FFE73C3C3C21BB2000000
40AB123450C0FFE73C3C3C21CC2000000
40AB123450C0FFE73C3C3C21DD2000000
40AB123450C0FFE73C3C3C21EE2000000
40AB123450C0FFE73C3C3C21FF2000000
40AB123450C0FFE73C3C3C22500000000
00AB123450C0FFE73C3C3C20050AB1234
FF0000000000000000000000000000000
